/* design/board_pkg.sv */
package board_pkg;

    // bus widths
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;

    // region codes carried down the pipeline
    typedef enum logic [1:0] {
        REG_LPMEM = 2'd0,
        REG_MEM0  = 2'd1,
        REG_MEM1  = 2'd2,
        REG_GPIO  = 2'd3
    } region_t;

    // address map, top nibble picks the region
    localparam addr_t LPMEM_BASE = 32'h0000_0000;
    localparam addr_t MEM0_BASE  = 32'h1000_0000;
    localparam addr_t MEM1_BASE  = 32'h2000_0000;
    localparam addr_t GPIO_BASE  = 32'h4000_0000;

    // gpio region holds a single word
    localparam int GPIO_SIZE = 4;

    // internal reset hold time in cycles
    localparam int RST_HOLD = 16;

endpackage

/* design/board_top.sv */
`timescale 1ns/1ps

module board_top import board_pkg::*; #(
    parameter int LPMEM_SIZE = 1024,
    parameter int MEM0_SIZE  = 4096,
    parameter int MEM1_SIZE  = 4096
) (
    input  logic       clk,
    input  logic       rstn,
    input  logic       req,
    input  logic       we,
    input  addr_t      addr,
    input  strb_t      be,
    input  data_t      wdata,
    output logic       rvalid,
    output data_t      rdata,
    output logic       err,
    output logic [7:0] gpio
);

    logic    rst_int;

    logic    s1_valid;
    region_t s1_region;
    logic    s1_err;
    logic    s1_we;
    addr_t   s1_index;
    strb_t   s1_be;
    data_t   s1_wdata;

    logic    lp_sel;
    logic    m0_sel;
    logic    m1_sel;
    logic    gp_sel;

    data_t   lp_rdata;
    data_t   m0_rdata;
    data_t   m1_rdata;
    data_t   gp_rdata;

    rst_stretch u_rst_stretch (
        .clk     (clk),
        .rstn    (rstn),
        .rst_int (rst_int)
    );

    bus_decode #(
        .LPMEM_SIZE (LPMEM_SIZE),
        .MEM0_SIZE  (MEM0_SIZE),
        .MEM1_SIZE  (MEM1_SIZE)
    ) u_bus_decode (
        .clk       (clk),
        .rst_int   (rst_int),
        .req       (req),
        .we        (we),
        .addr      (addr),
        .be        (be),
        .wdata     (wdata),
        .s1_valid  (s1_valid),
        .s1_region (s1_region),
        .s1_err    (s1_err),
        .s1_we     (s1_we),
        .s1_index  (s1_index),
        .s1_be     (s1_be),
        .s1_wdata  (s1_wdata)
    );

    // erroneous requests touch no target
    assign lp_sel = s1_valid && !s1_err && (s1_region == REG_LPMEM);
    assign m0_sel = s1_valid && !s1_err && (s1_region == REG_MEM0);
    assign m1_sel = s1_valid && !s1_err && (s1_region == REG_MEM1);
    assign gp_sel = s1_valid && !s1_err && (s1_region == REG_GPIO);

    mem_bank #(.SIZE (LPMEM_SIZE)) lpmem_bank (
        .clk   (clk),
        .sel   (lp_sel),
        .we    (s1_we),
        .index (s1_index),
        .be    (s1_be),
        .wdata (s1_wdata),
        .rdata (lp_rdata)
    );

    mem_bank #(.SIZE (MEM0_SIZE)) mem0_bank (
        .clk   (clk),
        .sel   (m0_sel),
        .we    (s1_we),
        .index (s1_index),
        .be    (s1_be),
        .wdata (s1_wdata),
        .rdata (m0_rdata)
    );

    mem_bank #(.SIZE (MEM1_SIZE)) mem1_bank (
        .clk   (clk),
        .sel   (m1_sel),
        .we    (s1_we),
        .index (s1_index),
        .be    (s1_be),
        .wdata (s1_wdata),
        .rdata (m1_rdata)
    );

    gpio_port u_gpio_port (
        .clk     (clk),
        .rst_int (rst_int),
        .sel     (gp_sel),
        .we      (s1_we),
        .be      (s1_be),
        .wdata   (s1_wdata),
        .rdata   (gp_rdata),
        .gpio    (gpio)
    );

    resp_merge u_resp_merge (
        .clk       (clk),
        .rst_int   (rst_int),
        .s1_valid  (s1_valid),
        .s1_region (s1_region),
        .s1_we     (s1_we),
        .s1_err    (s1_err),
        .lp_rdata  (lp_rdata),
        .m0_rdata  (m0_rdata),
        .m1_rdata  (m1_rdata),
        .gp_rdata  (gp_rdata),
        .rvalid    (rvalid),
        .rdata     (rdata),
        .err       (err)
    );

endmodule

/* design/bus_decode.sv */
`timescale 1ns/1ps

module bus_decode import board_pkg::*; #(
    parameter int LPMEM_SIZE = 1024,
    parameter int MEM0_SIZE  = 4096,
    parameter int MEM1_SIZE  = 4096
) (
    input  logic    clk,
    input  logic    rst_int,
    input  logic    req,
    input  logic    we,
    input  addr_t   addr,
    input  strb_t   be,
    input  data_t   wdata,
    output logic    s1_valid,
    output region_t s1_region,
    output logic    s1_err,
    output logic    s1_we,
    output addr_t   s1_index,
    output strb_t   s1_be,
    output data_t   s1_wdata
);

    region_t dec_region;
    logic    dec_err;
    addr_t   offset;
    addr_t   limit;

    // offset inside the region, nibble stripped
    assign offset = {4'h0, addr[27:0]};

    always_comb begin
        dec_region = REG_LPMEM;
        limit      = addr_t'(LPMEM_SIZE);
        dec_err    = 1'b0;
        if (addr[31:28] == LPMEM_BASE[31:28]) begin
            dec_region = REG_LPMEM;
            limit      = addr_t'(LPMEM_SIZE);
        end else if (addr[31:28] == MEM0_BASE[31:28]) begin
            dec_region = REG_MEM0;
            limit      = addr_t'(MEM0_SIZE);
        end else if (addr[31:28] == MEM1_BASE[31:28]) begin
            dec_region = REG_MEM1;
            limit      = addr_t'(MEM1_SIZE);
        end else if (addr[31:28] == GPIO_BASE[31:28]) begin
            dec_region = REG_GPIO;
            limit      = addr_t'(GPIO_SIZE);
        end else begin
            // unmapped nibble
            dec_err = 1'b1;
        end
        if (offset >= limit) begin
            dec_err = 1'b1;
        end
    end

    // valid is control state, the rest is payload
    always_ff @(posedge clk) begin
        if (rst_int) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= req;
        end
    end

    always_ff @(posedge clk) begin
        s1_region <= dec_region;
        s1_err    <= dec_err;
        s1_we     <= we;
        s1_index  <= offset >> 2;
        s1_be     <= be;
        s1_wdata  <= wdata;
    end

endmodule

/* design/gpio_port.sv */
`timescale 1ns/1ps

module gpio_port import board_pkg::*; (
    input  logic       clk,
    input  logic       rst_int,
    input  logic       sel,
    input  logic       we,
    input  strb_t      be,
    input  data_t      wdata,
    output data_t      rdata,
    output logic [7:0] gpio
);

    // output bank, only byte 0 is wired to pins
    always_ff @(posedge clk) begin
        if (rst_int) begin
            gpio <= 8'h00;
        end else if (sel && we && be[0]) begin
            gpio <= wdata[7:0];
        end
    end

    // readback lines up with mem_bank latency
    always_ff @(posedge clk) begin
        if (sel && !we) begin
            rdata <= {24'h0, gpio};
        end
    end

endmodule

/* design/mem_bank.sv */
`timescale 1ns/1ps

module mem_bank import board_pkg::*; #(
    parameter int SIZE = 1024
) (
    input  logic  clk,
    input  logic  sel,
    input  logic  we,
    input  addr_t index,
    input  strb_t be,
    input  data_t wdata,
    output data_t rdata
);

    localparam int DEPTH = SIZE / 4;
    localparam int AW    = $clog2(DEPTH);

    data_t         mem [DEPTH];
    logic [AW-1:0] word;

    // range already checked upstream, low bits are enough
    assign word = index[AW-1:0];

    always_ff @(posedge clk) begin
        if (sel) begin
            if (we) begin
                for (int b = 0; b < 4; b++) begin
                    if (be[b]) begin
                        mem[word][8*b +: 8] <= wdata[8*b +: 8];
                    end
                end
            end else begin
                rdata <= mem[word];
            end
        end
    end

endmodule

/* design/resp_merge.sv */
`timescale 1ns/1ps

module resp_merge import board_pkg::*; (
    input  logic    clk,
    input  logic    rst_int,
    input  logic    s1_valid,
    input  region_t s1_region,
    input  logic    s1_we,
    input  logic    s1_err,
    input  data_t   lp_rdata,
    input  data_t   m0_rdata,
    input  data_t   m1_rdata,
    input  data_t   gp_rdata,
    output logic    rvalid,
    output data_t   rdata,
    output logic    err
);

    logic    s2_valid;
    region_t s2_region;
    logic    s2_we;
    logic    s2_err;
    data_t   sel_rdata;

    // tags follow the request into the access stage
    always_ff @(posedge clk) begin
        if (rst_int) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s2_region <= s1_region;
        s2_we     <= s1_we;
        s2_err    <= s1_err;
    end

    always_comb begin
        case (s2_region)
            REG_LPMEM: sel_rdata = lp_rdata;
            REG_MEM0:  sel_rdata = m0_rdata;
            REG_MEM1:  sel_rdata = m1_rdata;
            default:   sel_rdata = gp_rdata;
        endcase
    end

    // reads always answer, writes only on error
    always_ff @(posedge clk) begin
        if (rst_int) begin
            rvalid <= 1'b0;
            err    <= 1'b0;
        end else begin
            rvalid <= s2_valid && !s2_we;
            err    <= s2_valid && s2_err;
        end
    end

    // no bank was selected for a bad address
    always_ff @(posedge clk) begin
        rdata <= s2_err ? '0 : sel_rdata;
    end

endmodule

/* design/rst_stretch.sv */
`timescale 1ns/1ps

module rst_stretch import board_pkg::*; (
    input  logic clk,
    input  logic rstn,
    output logic rst_int
);

    logic [3:0] count;

    // hold rst_int until the counter has seen RST_HOLD edges after release
    always_ff @(posedge clk) begin
        if (!rstn) begin
            count   <= 4'd0;
            rst_int <= 1'b1;
        end else if (rst_int) begin
            if (count == 4'(RST_HOLD - 1)) begin
                rst_int <= 1'b0;
            end else begin
                count <= count + 4'd1;
            end
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the board testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module board_tb -f vlog.f -o board_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# keep running past assertion errors so the testbench can report them
./obj_dir/board_sim +verilator+error+limit+100 > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see sim.log"
    exit 1
fi

if grep -q "^>>> PASS$" sim.log; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed, see sim.log"
exit 1

/* tb/board_assertions.sv */
`timescale 1ns/1ps

module board_assertions (
    input logic clk,
    input logic rst_int,
    input logic s1_valid,
    input logic s1_err,
    input logic rvalid,
    input logic err
);

    // bumped by every failing property
    int unsigned fail_count = 0;

    // err belongs to a bad request decoded two stages back
    assert property (@(posedge clk) err |-> $past(s1_valid && s1_err, 2))
        else begin
            fail_count++;
            $error("err raised without a bad request three edges earlier");
        end

    // response port stays quiet through the reset window
    assert property (@(posedge clk) rst_int |-> !rvalid)
        else begin
            fail_count++;
            $error("rvalid high while internal reset is active");
        end

    assert property (@(posedge clk) !rst_int |-> !$isunknown({rvalid, err}))
        else begin
            fail_count++;
            $error("rvalid or err unknown after reset");
        end

endmodule

/* tb/board_tb.sv */
`timescale 1ns/1ps

module board_tb import board_pkg::*; ();

    localparam int LP_BYTES = 1024;
    localparam int M0_BYTES = 4096;
    localparam int M1_BYTES = 4096;
    // the tests need about 300 cycles, this leaves a wide margin
    localparam int MAX_CYCLES = 2000;

    logic       clk;
    logic       rstn;
    logic       req;
    logic       we;
    addr_t      addr;
    strb_t      be;
    data_t      wdata;
    logic       rvalid;
    data_t      rdata;
    logic       err;
    logic [7:0] gpio;

    // reference state, memory keyed by word address
    data_t      mem_model [addr_t];
    logic [7:0] gpio_model;

    // expected responses in issue order
    logic       q_rvalid [$];
    logic       q_err [$];
    data_t      q_data [$];
    int         q_cyc [$];

    string      test_name;
    int         cycle = 0;
    int         checks;
    int         errors;
    int         test_base;

    board_top DUT (
        .clk    (clk),
        .rstn   (rstn),
        .req    (req),
        .we     (we),
        .addr   (addr),
        .be     (be),
        .wdata  (wdata),
        .rvalid (rvalid),
        .rdata  (rdata),
        .err    (err),
        .gpio   (gpio)
    );

    bind resp_merge board_assertions u_assert (
        .clk      (clk),
        .rst_int  (rst_int),
        .s1_valid (s1_valid),
        .s1_err   (s1_err),
        .rvalid   (rvalid),
        .err      (err)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    // expected response of one access, updates the model state
    function automatic void model_access(input logic is_wr, input addr_t a, input strb_t s,
            input data_t d, output logic resp, output logic exp_err, output data_t exp_data);
        int    size;
        addr_t key;
        data_t word;
        case (a[31:28])
            4'h0:    size = LP_BYTES;
            4'h1:    size = M0_BYTES;
            4'h2:    size = M1_BYTES;
            4'h4:    size = 4;
            default: size = 0;
        endcase
        // unmapped nibble has size zero
        exp_err  = ({4'h0, a[27:0]} >= addr_t'(size));
        resp     = !is_wr || exp_err;
        exp_data = '0;
        key      = {a[31:2], 2'b00};
        if (!exp_err && a[31:28] == 4'h4) begin
            if (is_wr && s[0]) begin
                gpio_model = d[7:0];
            end
            exp_data = {24'h0, gpio_model};
        end else if (!exp_err) begin
            word = mem_model.exists(key) ? mem_model[key] : '0;
            if (is_wr) begin
                for (int b = 0; b < 4; b++) begin
                    if (s[b]) begin
                        word[8*b +: 8] = d[8*b +: 8];
                    end
                end
                mem_model[key] = word;
            end
            exp_data = word;
        end
    endfunction

    // one request cycle; untracked requests are expected to be dropped
    task automatic issue(input logic is_wr, input addr_t a, input strb_t s, input data_t d,
            input logic track);
        logic  resp;
        logic  e;
        data_t x;
        @(posedge clk);
        #1;
        req   = 1'b1;
        we    = is_wr;
        addr  = a;
        be    = s;
        wdata = d;
        if (track) begin
            model_access(is_wr, a, s, d, resp, e, x);
            if (resp) begin
                q_rvalid.push_back(!is_wr);
                q_err.push_back(e);
                q_data.push_back(x);
                q_cyc.push_back(cycle);
            end
        end
    endtask

    task automatic drain();
        @(posedge clk);
        #1;
        req = 1'b0;
        we  = 1'b0;
        while (q_err.size() != 0) begin
            @(posedge clk);
        end
        // trailing writes still need to commit
        repeat (4) @(posedge clk);
    endtask

    task automatic check_gpio();
        checks++;
        if (gpio !== gpio_model) begin
            errors++;
            $display("Fail %s: gpio expected %h actual %h", test_name, gpio_model, gpio);
        end
    endtask

    task automatic end_test();
        $display("test %s done, %0d errors", test_name, errors - test_base);
        test_base = errors;
    endtask

    function automatic addr_t rand_addr();
        case ($urandom_range(0, 2))
            0:       return LPMEM_BASE | ($urandom_range(0, LP_BYTES / 4 - 1) << 2);
            1:       return MEM0_BASE | ($urandom_range(0, M0_BYTES / 4 - 1) << 2);
            default: return MEM1_BASE | ($urandom_range(0, M1_BYTES / 4 - 1) << 2);
        endcase
    endfunction

    // outputs are settled by the falling edge
    always @(negedge clk) begin
        if (rvalid === 1'b1 || err === 1'b1) begin
            checks++;
            if (q_err.size() == 0) begin
                errors++;
                $display("%s: response at cycle %0d with no request outstanding",
                         test_name, cycle);
            end else begin
                if (rvalid !== q_rvalid[0] || err !== q_err[0]) begin
                    errors++;
                    $display("Fail %s: rvalid,err expected %b,%b actual %b,%b", test_name,
                             q_rvalid[0], q_err[0], rvalid, err);
                end
                if (q_rvalid[0] && rdata !== q_data[0]) begin
                    errors++;
                    $display("Fail %s: rdata expected %h actual %h", test_name, q_data[0], rdata);
                end
                if (cycle - q_cyc[0] != 3) begin
                    errors++;
                    $display("Fail %s: latency expected 3 actual %0d", test_name,
                             cycle - q_cyc[0]);
                end
                void'(q_rvalid.pop_front());
                void'(q_err.pop_front());
                void'(q_data.pop_front());
                void'(q_cyc.pop_front());
            end
        end
    end

    initial begin
        addr_t a;
        addr_t pool [8];
        addr_t word_addr [3];
        addr_t bad_addr [6];
        void'($urandom(32'h4914_d326));
        rstn       = 1'b0;
        req        = 1'b0;
        we         = 1'b0;
        addr       = '0;
        be         = '0;
        wdata      = '0;
        gpio_model = 8'h00;
        checks     = 0;
        errors     = 0;
        test_base  = 0;
        a          = '0;
        repeat (10) @(posedge clk);
        #1;
        rstn = 1'b1;
        repeat (RST_HOLD + 2) @(posedge clk);

        test_name = "word_rw";
        word_addr = '{32'h0000_0010, 32'h1000_0ab0, 32'h2000_0ffc};
        foreach (word_addr[i]) begin
            issue(1'b1, word_addr[i], 4'hf, $urandom(), 1'b1);
            issue(1'b0, word_addr[i], 4'h0, '0, 1'b1);
        end
        drain();
        end_test();

        test_name = "byte_strobe";
        repeat (8) begin
            a = rand_addr();
            issue(1'b1, a, 4'hf, $urandom(), 1'b1);
            issue(1'b1, a, strb_t'($urandom()), $urandom(), 1'b1);
            issue(1'b0, a, 4'h0, '0, 1'b1);
        end
        drain();
        end_test();

        test_name = "stream";
        for (int i = 0; i < 8; i++) begin
            pool[i] = rand_addr();
            issue(1'b1, pool[i], 4'hf, $urandom(), 1'b1);
        end
        for (int i = 0; i < 64; i++) begin
            // every fourth op reads back the word just touched
            if (i % 4 == 3) begin
                issue(1'b0, a, 4'h0, '0, 1'b1);
            end else begin
                a = pool[$urandom_range(0, 7)];
                issue(1'($urandom_range(0, 1)), a, strb_t'($urandom()), $urandom(), 1'b1);
            end
        end
        drain();
        end_test();

        test_name = "gpio";
        issue(1'b1, GPIO_BASE, 4'hf, $urandom(), 1'b1);
        drain();
        check_gpio();
        issue(1'b1, GPIO_BASE, 4'he, $urandom(), 1'b1);
        drain();
        check_gpio();
        issue(1'b1, GPIO_BASE, 4'h1, $urandom(), 1'b1);
        issue(1'b0, GPIO_BASE, 4'h0, '0, 1'b1);
        drain();
        check_gpio();
        end_test();

        test_name = "range";
        // in-range words that the bad writes would alias onto
        issue(1'b1, 32'h0000_0000, 4'hf, $urandom(), 1'b1);
        issue(1'b1, 32'h1000_0000, 4'hf, $urandom(), 1'b1);
        issue(1'b1, 32'h2000_0004, 4'hf, $urandom(), 1'b1);
        bad_addr = '{32'h0000_0400, 32'h1000_1000, 32'h2000_1004,
                     32'h4000_0004, 32'h3000_0000, 32'hf000_0010};
        foreach (bad_addr[i]) begin
            issue(1'b0, bad_addr[i], 4'h0, '0, 1'b1);
            issue(1'b1, bad_addr[i], 4'hf, $urandom(), 1'b1);
        end
        issue(1'b0, 32'h0000_0000, 4'h0, '0, 1'b1);
        issue(1'b0, 32'h1000_0000, 4'h0, '0, 1'b1);
        issue(1'b0, 32'h2000_0004, 4'h0, '0, 1'b1);
        drain();
        check_gpio();
        end_test();

        test_name = "reset";
        @(posedge clk);
        #1;
        rstn       = 1'b0;
        gpio_model = 8'h00;
        repeat (10) @(posedge clk);
        #1;
        rstn = 1'b1;
        // all of these fall inside the stretch window
        repeat (4) begin
            issue(1'b1, 32'h0000_0000, 4'hf, 32'hdead_beef, 1'b0);
            issue(1'b0, GPIO_BASE, 4'h0, '0, 1'b0);
        end
        drain();
        repeat (RST_HOLD) @(posedge clk);
        check_gpio();
        issue(1'b0, GPIO_BASE, 4'h0, '0, 1'b1);
        issue(1'b0, 32'h0000_0000, 4'h0, '0, 1'b1);
        drain();
        end_test();

        $display("summary: %0d checks, %0d errors, %0d assertion failures", checks, errors,
                 DUT.u_resp_merge.u_assert.fail_count);
        if (errors == 0 && DUT.u_resp_merge.u_assert.fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* vlog.f */
design/board_pkg.sv
design/rst_stretch.sv
design/bus_decode.sv
design/mem_bank.sv
design/gpio_port.sv
design/resp_merge.sv
design/board_top.sv
tb/board_assertions.sv
tb/board_tb.sv
